//--- rtl/cpu_params.svh
// Datapath width, address width, register count, LED address and APB register offsets
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and instruction width
`define CPU_DATA_W     16

// Word address width, 256 words
`define CPU_ADDR_W     8

`define CPU_NREGS      8

// Core stores here also drive the LEDs
`define CPU_LED_ADDR   8'hFF

// APB byte offsets, memory sits below CTRL
`define CPU_APB_CTRL   12'h200
`define CPU_APB_STATUS 12'h204

`endif

//--- rtl/cpu_pkg.sv
// CPU package with state enum, opcode enum and decoded instruction struct
`default_nettype none

package cpu_pkg;

    // One state per instruction step
    typedef enum logic [2:0] {
        S_FETCH  = 3'd0,
        S_DECODE = 3'd1,
        S_EXEC   = 3'd2,
        S_MEM    = 3'd3,
        S_WB     = 3'd4,
        S_HALT   = 3'd5
    } cpu_state_e;

    // Instruction bits 15:12
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        LDI  = 4'h5,
        LD   = 4'h6,
        ST   = 4'h7,
        BZ   = 4'h8,
        JMP  = 4'h9,
        HALT = 4'hF   // Codes A to E are unused and run as no-ops
    } opcode_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [7:0] imm8;   // Overlaps rs, used by LDI, BZ and JMP
    } decoded_instr_t;

endpackage

`default_nettype wire

//--- rtl/mem_bus_if.sv
// Core-to-memory bus interface with core and memory modports
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

interface mem_bus_if;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] wdata;
    logic [`CPU_DATA_W-1:0] rdata;   // Word from previous req cycle
    logic                   wr_en;
    logic                   req;

    modport core (
        output addr,
        output wdata,
        output wr_en,
        output req,
        input  rdata
    );

    modport memory (
        input  addr,
        input  wdata,
        input  wr_en,
        input  req,
        output rdata
    );
endinterface

`default_nettype wire

//--- rtl/cpu_control.sv
// Control FSM sequencing fetch, decode, execute, memory, writeback and halt
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  cpu_pkg::opcode_e    opcode,
    output cpu_pkg::cpu_state_e state,
    output logic                halted
);
    import cpu_pkg::*;

    cpu_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH:  next_state = S_DECODE;
            S_DECODE: next_state = S_EXEC;
            S_EXEC: begin
                if (opcode == HALT) begin
                    next_state = S_HALT;
                end else if (opcode inside {LD, ST}) begin
                    next_state = S_MEM;
                end else begin
                    next_state = S_WB;   // ALU, LDI, branches and no-ops
                end
            end
            S_MEM:    next_state = S_WB;
            S_WB:     next_state = S_FETCH;
            S_HALT:   next_state = S_HALT;   // Left only by clearing run
            default:  next_state = S_FETCH;
        endcase

        // Stopped core idles in fetch
        if (!run) begin
            next_state = S_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_FETCH;
        end else begin
            state <= next_state;
        end
    end

    assign halted = (state == S_HALT);

    // Decoded opcode is held from EXEC through MEM
    a_mem_only_ld_st: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == S_MEM) |-> (opcode inside {LD, ST})
    );

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
// Program counter with increment, branch load, hold and clear
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module pc_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   clear,
    input  cpu_pkg::cpu_state_e    state,
    input  logic                   branch,
    input  logic [`CPU_ADDR_W-1:0] target,
    output logic [`CPU_ADDR_W-1:0] pc
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (clear) begin
            pc <= '0;                  // Run cleared, restart from 0
        end else if (state == S_WB) begin
            if (branch) begin
                pc <= target;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
// Instruction register and field decoder
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module instr_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_pkg::cpu_state_e     state,
    input  logic [`CPU_DATA_W-1:0]  word,
    output cpu_pkg::decoded_instr_t instr
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] ir;

    // Memory word is valid in DECODE, one cycle after the fetch request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == S_DECODE) begin
            ir <= word;
        end
    end

    // Unlisted codes keep their raw value and hit the default branches downstream,
    // so they pass through EXEC and WB without side effects
    assign instr.opcode = opcode_e'(ir[15:12]);
    assign instr.rd     = ir[11:9];
    assign instr.rs     = ir[8:6];
    assign instr.imm8   = ir[7:0];

endmodule

`default_nettype wire

//--- rtl/alu.sv
// ALU with zero flag, branch decision and register write enable
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module alu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cpu_pkg::cpu_state_e     state,
    input  cpu_pkg::decoded_instr_t instr,
    input  logic [`CPU_DATA_W-1:0]  rd_data,
    input  logic [`CPU_DATA_W-1:0]  rs_data,
    output logic [`CPU_DATA_W-1:0]  result,
    output logic                    branch,
    output logic                    reg_we
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W-1:0] alu_out;
    logic                   zero;
    logic                   take;
    logic                   writes_rd;

    assign zero = (rd_data == '0);   // Tested by BZ

    always_comb begin
        case (instr.opcode)
            ADD:     alu_out = rd_data + rs_data;
            SUB:     alu_out = rd_data - rs_data;
            AND:     alu_out = rd_data & rs_data;
            OR:      alu_out = rd_data | rs_data;
            XOR:     alu_out = rd_data ^ rs_data;
            LDI:     alu_out = {{(`CPU_DATA_W-8){1'b0}}, instr.imm8};
            default: alu_out = '0;
        endcase
    end

    assign take      = (instr.opcode == JMP) || (instr.opcode == BZ && zero);
    assign writes_rd = instr.opcode inside {ADD, SUB, AND, OR, XOR, LDI, LD};

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            result <= alu_out;
        end
    end

    // Decisions for the WB step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            branch <= 1'b0;
            reg_we <= 1'b0;
        end else if (state == S_EXEC) begin
            branch <= take;
            reg_we <= writes_rd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
// Eight-entry register file with two read ports and one write port
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module register_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             we,
    input  logic [$clog2(`CPU_NREGS)-1:0]    rd_sel,
    input  logic [$clog2(`CPU_NREGS)-1:0]    rs_sel,
    input  logic [`CPU_DATA_W-1:0]           wdata,
    output logic [`CPU_DATA_W-1:0]           rd_data,
    output logic [`CPU_DATA_W-1:0]           rs_data
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];

    // Writes always target rd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[rd_sel] <= wdata;
        end
    end

    assign rd_data = regs[rd_sel];
    assign rs_data = regs[rs_sel];

endmodule

`default_nettype wire

//--- rtl/unified_mem.sv
// Shared program and data memory with host port and LED register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module unified_mem (
    input  logic                   clk,
    input  logic                   rst_n,
    mem_bus_if.memory              bus,
    input  logic                   host_en,
    input  logic                   host_we,
    input  logic [`CPU_ADDR_W-1:0] host_addr,
    input  logic [`CPU_DATA_W-1:0] host_wdata,
    output logic [`CPU_DATA_W-1:0] host_rdata,
    output logic [7:0]             leds
);

    logic [`CPU_DATA_W-1:0] mem [2**`CPU_ADDR_W];
    logic [`CPU_ADDR_W-1:0] port_addr;
    logic [`CPU_DATA_W-1:0] port_wdata;
    logic [`CPU_DATA_W-1:0] rd_q;
    logic                   port_en;
    logic                   port_we;
    logic                   led_store;

    // Host and core never share a cycle, so one port serves both
    assign port_en    = host_en || bus.req;
    assign port_we    = host_en ? host_we : bus.wr_en;
    assign port_addr  = host_en ? host_addr : bus.addr;
    assign port_wdata = host_en ? host_wdata : bus.wdata;

    always_ff @(posedge clk) begin
        if (port_en) begin
            if (port_we) begin
                mem[port_addr] <= port_wdata;
            end
            rd_q <= mem[port_addr];   // Read before write on same address
        end
    end

    assign bus.rdata  = rd_q;
    assign host_rdata = rd_q;

    assign led_store = bus.req && bus.wr_en && (bus.addr == `CPU_LED_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            leds <= '0;
        end else if (led_store) begin
            leds <= bus.wdata[7:0];
        end
    end

    // Host access is gated by run in the core top
    a_host_core_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(host_en && bus.req)
    );

endmodule

`default_nettype wire

//--- rtl/cpu_core.sv
// CPU top level with APB slave, control and status registers and datapath
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [11:0]            paddr,
    input  logic [`CPU_DATA_W-1:0] pwdata,
    output logic [`CPU_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [7:0]             leds
);
    import cpu_pkg::*;

    cpu_state_e             state;
    decoded_instr_t         instr;
    logic                   run;
    logic                   halted;
    logic                   branch;
    logic                   reg_we;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] rd_data;
    logic [`CPU_DATA_W-1:0] rs_data;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] wb_data;
    logic [`CPU_DATA_W-1:0] host_rdata;
    logic                   host_en;
    logic                   apb_setup;
    logic                   apb_access;
    logic                   mem_sel;
    logic                   ctrl_sel;
    logic                   status_sel;

    mem_bus_if bus ();

    assign apb_setup  = psel && !penable;
    assign apb_access = psel && penable;
    assign mem_sel    = (paddr < `CPU_APB_CTRL);
    assign ctrl_sel   = (paddr == `CPU_APB_CTRL);
    assign status_sel = (paddr == `CPU_APB_STATUS);

    // Reads go out in setup so the word is back for the access cycle
    assign host_en = mem_sel && !run && (pwrite ? apb_access : apb_setup);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (apb_access && pwrite && ctrl_sel) begin
            run <= pwdata[0];
        end
    end

    assign pready  = 1'b1;
    assign pslverr = apb_access && (mem_sel ? run : !(ctrl_sel || status_sel));

    always_comb begin
        prdata = '0;
        if (apb_access && !pwrite) begin
            if (mem_sel && !run) begin
                prdata = host_rdata;
            end else if (ctrl_sel) begin
                prdata = {{(`CPU_DATA_W-1){1'b0}}, run};
            end else if (status_sel) begin
                prdata = {{(`CPU_DATA_W-9){1'b0}}, halted, leds};
            end
        end
    end

    // Fetch uses pc, LD and ST use the address in rs
    assign bus.req   = run && (state == S_FETCH || state == S_MEM);
    assign bus.wr_en = (state == S_MEM) && (instr.opcode == ST);
    assign bus.addr  = (state == S_MEM) ? rs_data[`CPU_ADDR_W-1:0] : pc;
    assign bus.wdata = rd_data;

    assign wb_data = (instr.opcode == LD) ? bus.rdata : alu_result;

    cpu_control u_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .opcode (instr.opcode),
        .state  (state),
        .halted (halted)
    );

    pc_unit u_pc (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (!run),
        .state  (state),
        .branch (branch),
        .target (instr.imm8),
        .pc     (pc)
    );

    instr_decoder u_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .word  (bus.rdata),
        .instr (instr)
    );

    alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .instr   (instr),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .result  (alu_result),
        .branch  (branch),
        .reg_we  (reg_we)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (reg_we && state == S_WB),
        .rd_sel  (instr.rd),
        .rs_sel  (instr.rs),
        .wdata   (wb_data),
        .rd_data (rd_data),
        .rs_data (rs_data)
    );

    unified_mem u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus.memory),
        .host_en    (host_en),
        .host_we    (pwrite),
        .host_addr  (paddr[8:1]),
        .host_wdata (pwdata),
        .host_rdata (host_rdata),
        .leds       (leds)
    );

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
// Stimulus-file-driven testbench for the CPU core with APB driver and checks
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpu_tb;

    localparam int APB_TIMEOUT  = 16;     // Cycles to wait for pready
    localparam int HALT_TIMEOUT = 2000;   // Cycles to wait for halted

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  leds;
    int          cycle_count = 0;

    cpu_core dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .leds    (leds)
    );

    always #50 clk = ~clk;   // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // One APB transfer, setup then access, sampled at the completing edge
    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [15:0] wdata, output logic [15:0] rdata,
                                output logic err);
        int waits;
        waits = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (pready !== 1'b1) begin
            waits++;
            if (waits > APB_TIMEOUT) begin
                abort_run($sformatf("APB transfer to offset %h never completed", addr));
            end
            @(posedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Polls STATUS until halted, then checks the LED value on both paths
    task automatic wait_for_halt(input logic [7:0] led_exp);
        logic [15:0] status;
        logic        err;
        int          start;
        status = '0;
        start  = cycle_count;
        while (!status[8]) begin
            if (cycle_count - start > HALT_TIMEOUT) begin
                abort_run("core did not halt within 2000 cycles");
            end
            apb_transfer(1'b0, `CPU_APB_STATUS, '0, status, err);
            check_value("pslverr", 16'h0, {15'b0, err});
        end
        check_value("status", {7'b0, 1'b1, led_exp}, status);
        check_value("leds", {8'b0, led_exp}, {8'b0, leds});
    endtask

    initial begin
        int          fd;
        int          code;
        int          lines_run;
        string       line;
        logic [7:0]  op;
        logic [11:0] addr;
        logic [15:0] data;
        logic [15:0] rdata;
        logic        err_exp;
        logic        err;

        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        lines_run   = 0;

        repeat (3) @(negedge clk);   // Three rising edges in reset
        rst_n = 1'b1;

        fd = $fopen("dv/cpu_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open stimulus file dv/cpu_stim.txt");
        end

        while (!$feof(fd)) begin
            line = "";
            op   = 8'h00;
            code = $fgets(line, fd);
            if (code > 0) begin
                code = $sscanf(line, "%c %h %h %h", op, addr, data, err_exp);
            end
            // Comment and blank lines
            if (code <= 0 || op == "#" || op == 8'h0a || op == 8'h0d) begin
                continue;
            end
            if (code != 4) begin
                abort_run($sformatf("malformed stimulus line: %s", line));
            end
            case (op)
                "W": begin
                    apb_transfer(1'b1, addr, data, rdata, err);
                    check_value("pslverr", {15'b0, err_exp}, {15'b0, err});
                end
                "R": begin
                    apb_transfer(1'b0, addr, '0, rdata, err);
                    check_value("prdata", data, rdata);
                    check_value("pslverr", {15'b0, err_exp}, {15'b0, err});
                end
                "H":     wait_for_halt(data[7:0]);
                default: abort_run($sformatf("unknown stimulus command %c", op));
            endcase
            lines_run++;
        end
        $fclose(fd);

        if (lines_run == 0) begin
            abort_run("stimulus file held no commands");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/cpu_stim.txt
# Columns: command, APB byte offset (hex), data (hex), expected pslverr
# W writes data, R reads and expects data, H waits for halt and expects data as the LEDs
R 200 0000 0
R 204 0000 0
W 000 523C 0  # 00 LDI r1,3C
W 002 540F 0  # 01 LDI r2,0F
W 004 56A5 0  # 02 LDI r3,A5
W 006 0280 0  # 03 ADD r1,r2 -> 4B
W 008 42C0 0  # 04 XOR r1,r3 -> EE
W 00A 1280 0  # 05 SUB r1,r2 -> DF
W 00C 34C0 0  # 06 OR  r2,r3 -> AF
W 00E 2280 0  # 07 AND r1,r2 -> 8F
W 010 5C80 0  # 08 LDI r6,80
W 012 7380 0  # 09 ST  r1,[r6]
W 014 6980 0  # 0A LD  r4,[r6] -> 8F
W 016 5A03 0  # 0B LDI r5,3 loop count
W 018 5000 0  # 0C LDI r0,0
W 01A 5401 0  # 0D LDI r2,1
W 01C 8A13 0  # 0E BZ  r5,13
W 01E 1A80 0  # 0F SUB r5,r2
W 020 0080 0  # 10 ADD r0,r2
W 022 900E 0  # 11 JMP 0E
W 024 F000 0  # 12 HALT, skipped by JMP
W 026 0100 0  # 13 ADD r0,r4 -> 3 + 8F = 92
W 028 5EFF 0  # 14 LDI r7,FF
W 02A 71C0 0  # 15 ST  r0,[r7] LEDs
W 02C F000 0  # 16 HALT
R 000 523C 0
R 01C 8A13 0
W 080 BEEF 0  # Marker word 40
R 080 BEEF 0
W 200 0001 0  # Start
R 200 0001 0
R 080 0000 1  # Memory blocked while running
W 080 0000 1
H 000 0092 0
R 204 0192 0
W 208 FFFF 1  # Unmapped offsets
R 208 0000 1
W 3FE 0000 1
W 200 0000 0  # Stop clears halted, LEDs stay
R 204 0092 0
R 200 0000 0
R 100 008F 0  # Word 80 from ST
R 1FE 0092 0  # Word FF holds the LED store
R 080 BEEF 0
R 000 523C 0
W 100 5555 0  # Rerun must store 8F again
R 100 5555 0
W 200 0001 0
H 000 0092 0
W 200 0000 0
R 100 008F 0
R 204 0092 0

//--- flist.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/cpu_control.sv
rtl/pc_unit.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/register_file.sv
rtl/unified_mem.sv
rtl/cpu_core.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/mem_bus_if.sv
      - rtl/cpu_control.sv
      - rtl/pc_unit.sv
      - rtl/instr_decoder.sv
      - rtl/alu.sv
      - rtl/register_file.sv
      - rtl/unified_mem.sv
      - rtl/cpu_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/cpu_tb.sv
